// File: source/bp_params.svh
`ifndef BP_PARAMS_SVH
`define BP_PARAMS_SVH

// ====================
// Front end geometry
// ====================

// Address width in bits
`define BP_ADDR_W 32

// Instruction words fetched per cycle
`define BP_LANES 5

// Resolve ports coming back from the back end
`define BP_RES_PORTS 3

// Target table depth and its index width
`define BP_ENTRIES 16
`define BP_IDX_W 4

// First fetch address out of reset
`define BP_RESET_PC 32'h0000_1000

`endif

// File: source/bp_pkg.sv
`include "bp_params.svh"

package bp_pkg;

    // ====================
    // Scalar types
    // ====================

    // One byte address
    typedef logic [`BP_ADDR_W-1:0] addr_t;
    // One RISC-V instruction word
    typedef logic [31:0] instr_t;
    // Target table index, PC bits 5 down to 2
    typedef logic [`BP_IDX_W-1:0] tbl_idx_t;
    // One bit per fetch lane
    typedef logic [`BP_LANES-1:0] lane_mask_t;
    // Lane number, 0 is the oldest
    typedef logic [2:0] lane_idx_t;

    // ====================
    // Bundles
    // ====================

    // Five words from consecutive addresses starting at pc
    typedef struct packed {
        logic                     valid;
        addr_t                    pc;
        instr_t [`BP_LANES-1:0]   instr;
    } fetch_bundle_t;

    // Predecode result, JALR lanes and the PC of every lane
    typedef struct packed {
        lane_mask_t               jalr_mask;
        addr_t [`BP_LANES-1:0]    pc;
    } lane_info_t;

    // One resolved control transfer from the back end
    // is_branch set for a conditional branch, clear for a JALR
    typedef struct packed {
        logic                     valid;
        logic                     mispredict;
        logic                     is_branch;
        addr_t                    jalr_pc;
        addr_t                    correct_pc;
    } resolve_t;

    // Predicted target of the earliest JALR in the bundle
    typedef struct packed {
        logic                     valid;
        lane_idx_t                lane;
        addr_t                    target;
    } jalr_pred_t;

endpackage

// File: source/jalr_predecode.sv
`include "bp_params.svh"

module jalr_predecode (
    input  bp_pkg::fetch_bundle_t fetch_i,
    output bp_pkg::lane_info_t    lanes_o
);

    // JALR encoding, I-type with funct3 zero
    localparam logic [6:0] OPC_JALR = 7'b1100111;
    localparam logic [2:0] F3_JALR  = 3'b000;

    // Per lane instruction fields
    logic [6:0] lane_opcode [`BP_LANES];
    logic [2:0] lane_funct3 [`BP_LANES];

    // Raw JALR match before the bundle valid gate
    bp_pkg::lane_mask_t jalr_raw;

    // ====================
    // Field extraction
    // ====================
    always_comb begin
        for (int l = 0; l < `BP_LANES; l++) begin
            lane_opcode[l] = fetch_i.instr[l][6:0];
            lane_funct3[l] = fetch_i.instr[l][14:12];
        end
    end

    // ====================
    // Lane decode
    // ====================
    always_comb begin
        for (int l = 0; l < `BP_LANES; l++) begin
            jalr_raw[l] = (lane_opcode[l] == OPC_JALR) && (lane_funct3[l] == F3_JALR);
        end
    end

    // ====================
    // Lane info
    // ====================
    always_comb begin
        // Words sit at consecutive word addresses
        for (int l = 0; l < `BP_LANES; l++) begin
            lanes_o.pc[l] = fetch_i.pc + bp_pkg::addr_t'(4 * l);
        end
        // No JALR lanes from an empty bundle
        if (fetch_i.valid) begin
            lanes_o.jalr_mask = jalr_raw;
        end else begin
            lanes_o.jalr_mask = '0;
        end
    end

endmodule

// File: source/jalr_target_table.sv
`include "bp_params.svh"

module jalr_target_table (
    input  logic                                  clk,
    input  logic                                  reset,
    input  bp_pkg::lane_info_t                    lanes_i,
    input  bp_pkg::resolve_t [`BP_RES_PORTS-1:0]  res_i,
    output bp_pkg::jalr_pred_t                    pred_o
);

    // Table state, one valid bit and one target per entry
    logic [`BP_ENTRIES-1:0] entry_valid_q;
    bp_pkg::addr_t          entry_target_q [`BP_ENTRIES];

    // Per lane lookup
    bp_pkg::tbl_idx_t [`BP_LANES-1:0] lookup_idx;
    logic [`BP_LANES-1:0]             lane_hit;
    bp_pkg::addr_t                    lane_target [`BP_LANES];

    // Earliest JALR lane
    logic              sel_found;
    bp_pkg::lane_idx_t sel_lane;

    // Training per resolve port
    logic [`BP_RES_PORTS-1:0]             train_en;
    bp_pkg::tbl_idx_t [`BP_RES_PORTS-1:0] train_idx;

    // ====================
    // Parallel lookup
    // ====================
    always_comb begin
        for (int l = 0; l < `BP_LANES; l++) begin
            // Direct mapped on the word address bits
            lookup_idx[l]  = lanes_i.pc[l][`BP_IDX_W+1:2];
            lane_hit[l]    = entry_valid_q[lookup_idx[l]];
            lane_target[l] = entry_target_q[lookup_idx[l]];
        end
    end

    // ====================
    // Earliest lane select
    // ====================
    always_comb begin
        sel_found = 1'b0;
        sel_lane  = '0;
        // Walk down so the lowest JALR lane is kept
        for (int l = `BP_LANES - 1; l >= 0; l--) begin
            if (lanes_i.jalr_mask[l]) begin
                sel_found = 1'b1;
                sel_lane  = bp_pkg::lane_idx_t'(l);
            end
        end
    end

    always_comb begin
        pred_o = '0;
        // Only the earliest JALR counts; a miss there gives no prediction
        if (sel_found && lane_hit[sel_lane]) begin
            pred_o.valid  = 1'b1;
            pred_o.lane   = sel_lane;
            pred_o.target = lane_target[sel_lane];
        end
    end

    // ====================
    // Training
    // ====================
    always_comb begin
        for (int p = 0; p < `BP_RES_PORTS; p++) begin
            // JALR mispredicts only, branches are ignored here
            train_en[p]  = res_i[p].valid && res_i[p].mispredict && !res_i[p].is_branch;
            train_idx[p] = res_i[p].jalr_pc[`BP_IDX_W+1:2];
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            entry_valid_q <= '0;
            for (int e = 0; e < `BP_ENTRIES; e++) begin
                entry_target_q[e] <= '0;
            end
        end else begin
            // Highest port first so port 0 lands last on a collision
            for (int p = `BP_RES_PORTS - 1; p >= 0; p--) begin
                if (train_en[p]) begin
                    entry_valid_q[train_idx[p]]  <= 1'b1;
                    entry_target_q[train_idx[p]] <= res_i[p].correct_pc;
                end
            end
        end
    end

    // ====================
    // Assertions
    // ====================

    // A prediction always belongs to a lane that predecode marked as JALR
    a_pred_on_jalr : assert property (
        @(posedge clk) disable iff (!reset)
        pred_o.valid |-> lanes_i.jalr_mask[pred_o.lane]
    ) else $error("prediction on a lane without a JALR");

endmodule

// File: source/fetch_pc_gen.sv
`include "bp_params.svh"

module fetch_pc_gen (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  stall_i,
    input  logic                                  fetch_valid_i,
    input  bp_pkg::jalr_pred_t                    pred_i,
    input  bp_pkg::resolve_t [`BP_RES_PORTS-1:0]  res_i,
    output bp_pkg::addr_t                         fetch_pc_o
);

    // Bundle size in bytes, five words
    localparam bp_pkg::addr_t SEQ_STEP = bp_pkg::addr_t'(`BP_LANES * 4);

    // Fetch PC register and its next value
    bp_pkg::addr_t pc_q;
    bp_pkg::addr_t pc_d;

    // Back end redirect
    logic          redirect;
    bp_pkg::addr_t redirect_pc;

    // ====================
    // Redirect select
    // ====================
    always_comb begin
        redirect    = 1'b0;
        redirect_pc = '0;
        // Any mispredict, branch or JALR, lowest port kept
        for (int p = `BP_RES_PORTS - 1; p >= 0; p--) begin
            if (res_i[p].valid && res_i[p].mispredict) begin
                redirect    = 1'b1;
                redirect_pc = res_i[p].correct_pc;
            end
        end
    end

    // ====================
    // Next PC
    // ====================
    always_comb begin
        pc_d = pc_q;
        if (redirect) begin
            // Redirect beats stall
            pc_d = redirect_pc;
        end else if (stall_i) begin
            pc_d = pc_q;
        end else if (fetch_valid_i && pred_i.valid) begin
            pc_d = pred_i.target;
        end else if (fetch_valid_i) begin
            pc_d = pc_q + SEQ_STEP;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc_q <= `BP_RESET_PC;
        end else begin
            pc_q <= pc_d;
        end
    end

    assign fetch_pc_o = pc_q;

    // ====================
    // Assertions
    // ====================

    // Targets from the table and the back end keep the PC on word boundaries
    a_pc_aligned : assert property (
        @(posedge clk) disable iff (!reset)
        fetch_pc_o[1:0] == 2'b00
    ) else $error("fetch PC not word aligned");

    // Stall without redirect freezes the PC for the next cycle
    a_stall_holds : assert property (
        @(posedge clk) disable iff (!reset)
        (stall_i && !redirect) |=> $stable(fetch_pc_o)
    ) else $error("fetch PC moved during stall");

endmodule

// File: source/jalr_frontend.sv
`include "bp_params.svh"

module jalr_frontend (
    input  logic                                  clk,
    input  logic                                  reset,
    // Fetched bundle, pc follows fetch_pc_o
    input  bp_pkg::fetch_bundle_t                 fetch_i,
    // Resolve results from the back end
    input  bp_pkg::resolve_t [`BP_RES_PORTS-1:0]  res_i,
    // Back-pressure on the fetch PC
    input  logic                                  stall_i,
    output bp_pkg::addr_t                         fetch_pc_o,
    output bp_pkg::jalr_pred_t                    pred_o
);

    // Predecode to table
    bp_pkg::lane_info_t lanes;

    // ====================
    // Predecode
    // ====================

    // JALR lanes and lane PCs of the current bundle
    jalr_predecode i_jalr_predecode (
        .fetch_i (fetch_i),
        .lanes_o (lanes)
    );

    // ====================
    // Target table
    // ====================

    // Same cycle lookup, trains on JALR mispredicts
    jalr_target_table i_jalr_target_table (
        .clk     (clk),
        .reset   (reset),
        .lanes_i (lanes),
        .res_i   (res_i),
        .pred_o  (pred_o)
    );

    // ====================
    // Fetch PC
    // ====================

    // Redirect, stall, prediction, then sequential
    fetch_pc_gen i_fetch_pc_gen (
        .clk           (clk),
        .reset         (reset),
        .stall_i       (stall_i),
        .fetch_valid_i (fetch_i.valid),
        .pred_i        (pred_o),
        .res_i         (res_i),
        .fetch_pc_o    (fetch_pc_o)
    );

endmodule

// File: sim/jalr_frontend_tb.sv
`include "bp_params.svh"

module jalr_frontend_tb;

    logic                                 clk;
    logic                                 reset;
    bp_pkg::fetch_bundle_t                fetch_i;
    bp_pkg::resolve_t [`BP_RES_PORTS-1:0] res_i;
    logic                                 stall_i;
    bp_pkg::addr_t                        fetch_pc_o;
    bp_pkg::jalr_pred_t                   pred_o;

    // Resolve results queued for the next driven cycle
    bp_pkg::resolve_t [`BP_RES_PORTS-1:0] res_pending;

    // Shadow copy of the target table and the expected fetch PC
    logic [`BP_ENTRIES-1:0] shadow_valid;
    bp_pkg::addr_t          shadow_target [`BP_ENTRIES];
    bp_pkg::addr_t          model_pc;

    integer seed;
    int     errors;
    int     checks;

    jalr_frontend i_jalr_frontend (
        .clk        (clk),
        .reset      (reset),
        .fetch_i    (fetch_i),
        .res_i      (res_i),
        .stall_i    (stall_i),
        .fetch_pc_o (fetch_pc_o),
        .pred_o     (pred_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ====================
    // Reference model
    // ====================

    // Earliest JALR lane, predicted only on a valid shadow entry
    function automatic bp_pkg::jalr_pred_t ref_predict(bp_pkg::fetch_bundle_t b);
        bp_pkg::jalr_pred_t p;
        bp_pkg::addr_t      lane_pc;
        bp_pkg::tbl_idx_t   idx;
        logic               found;
        p = '0;
        found = 1'b0;
        for (int l = 0; l < `BP_LANES; l++) begin
            lane_pc = b.pc + bp_pkg::addr_t'(4 * l);
            idx = lane_pc[5:2];
            if (b.valid && !found && b.instr[l][6:0] == 7'b1100111
                    && b.instr[l][14:12] == 3'b000) begin
                found = 1'b1;
                if (shadow_valid[idx]) begin
                    p.valid = 1'b1;
                    p.lane = bp_pkg::lane_idx_t'(l);
                    p.target = shadow_target[idx];
                end
            end
        end
        return p;
    endfunction

    // Redirect, then stall, then prediction, then PC plus 20
    function automatic bp_pkg::addr_t ref_next_pc(
        bp_pkg::addr_t                        pc,
        bp_pkg::fetch_bundle_t                b,
        bp_pkg::jalr_pred_t                   pred,
        bp_pkg::resolve_t [`BP_RES_PORTS-1:0] r,
        logic                                 stall
    );
        bp_pkg::addr_t nxt;
        logic          redirected;
        nxt = pc;
        redirected = 1'b0;
        for (int i = 0; i < `BP_RES_PORTS; i++) begin
            if (!redirected && r[i].valid && r[i].mispredict) begin
                redirected = 1'b1;
                nxt = r[i].correct_pc;
            end
        end
        if (!redirected && !stall && b.valid) begin
            if (pred.valid) begin
                nxt = pred.target;
            end else begin
                nxt = pc + 32'd20;
            end
        end
        return nxt;
    endfunction

    // First JALR mispredict to an index claims it
    function automatic void train_shadow(bp_pkg::resolve_t [`BP_RES_PORTS-1:0] r);
        logic [`BP_ENTRIES-1:0] written;
        bp_pkg::tbl_idx_t       idx;
        written = '0;
        for (int i = 0; i < `BP_RES_PORTS; i++) begin
            idx = r[i].jalr_pc[5:2];
            if (r[i].valid && r[i].mispredict && !r[i].is_branch && !written[idx]) begin
                written[idx] = 1'b1;
                shadow_valid[idx] = 1'b1;
                shadow_target[idx] = r[i].correct_pc;
            end
        end
    endfunction

    // ====================
    // Compare process
    // ====================
    initial begin
        bp_pkg::jalr_pred_t exp_pred;
        forever begin
            @(negedge clk);
            if (reset) begin
                exp_pred = ref_predict(fetch_i);
                checks++;
                if (fetch_pc_o !== model_pc) begin
                    $display("CHECK FAILED fetch_pc_o got %h expected %h", fetch_pc_o, model_pc);
                    errors++;
                end
                if (pred_o.valid !== exp_pred.valid) begin
                    $display("CHECK FAILED pred_o.valid got %h expected %h",
                             pred_o.valid, exp_pred.valid);
                    errors++;
                end else if (exp_pred.valid && pred_o.lane !== exp_pred.lane) begin
                    $display("CHECK FAILED pred_o.lane got %h expected %h",
                             pred_o.lane, exp_pred.lane);
                    errors++;
                end else if (exp_pred.valid && pred_o.target !== exp_pred.target) begin
                    $display("CHECK FAILED pred_o.target got %h expected %h",
                             pred_o.target, exp_pred.target);
                    errors++;
                end
                // State for the coming edge
                model_pc = ref_next_pc(model_pc, fetch_i, exp_pred, res_i, stall_i);
                train_shadow(res_i);
            end
        end
    end

    // ====================
    // Stimulus helpers
    // ====================

    // Random words, JALR forced into the chosen lanes only
    function automatic bp_pkg::fetch_bundle_t make_bundle(
        bp_pkg::addr_t pc, bp_pkg::lane_mask_t jalr_lanes, logic valid);
        bp_pkg::fetch_bundle_t b;
        bp_pkg::instr_t        w;
        b.valid = valid;
        b.pc = pc;
        for (int l = 0; l < `BP_LANES; l++) begin
            w = $random(seed);
            if (jalr_lanes[l]) begin
                w[14:12] = 3'b000;
                w[6:0] = 7'b1100111;
            end else if (w[6:0] == 7'b1100111) begin
                // Stray JALR opcode becomes ADDI
                w[6:0] = 7'b0010011;
            end
            b.instr[l] = w;
        end
        return b;
    endfunction

    task automatic post_resolve(input int port, input logic is_branch, input logic mispredict,
                                input bp_pkg::addr_t jalr_pc, input bp_pkg::addr_t correct_pc);
        res_pending[port].valid = 1'b1;
        res_pending[port].mispredict = mispredict;
        res_pending[port].is_branch = is_branch;
        res_pending[port].jalr_pc = jalr_pc;
        res_pending[port].correct_pc = correct_pc;
    endtask

    // One fetch cycle, returns at the falling edge
    task automatic run_cycle(input bp_pkg::lane_mask_t jalr_lanes, input logic valid,
                             input logic stall);
        @(posedge clk);
        // Bundle pc tracks the expected fetch_pc_o, checked every cycle
        fetch_i <= make_bundle(model_pc, jalr_lanes, valid);
        res_i <= res_pending;
        stall_i <= stall;
        res_pending = '0;
        @(negedge clk);
    endtask

    task automatic wait_for_pc(input bp_pkg::addr_t pc, input int limit);
        int n;
        n = 0;
        while (fetch_pc_o !== pc && n < limit) begin
            run_cycle('0, 1'b0, 1'b0);
            n++;
        end
        if (fetch_pc_o !== pc) begin
            $display("Timeout: fetch PC never reached %h within %0d cycles", pc, limit);
            errors++;
        end
    endtask

    task automatic redirect_to(input bp_pkg::addr_t pc);
        post_resolve(0, 1'b1, 1'b1, '0, pc);
        run_cycle('0, 1'b0, 1'b0);
        wait_for_pc(pc, 4);
    endtask

    task automatic expect_pred(input logic valid, input bp_pkg::lane_idx_t lane,
                               input bp_pkg::addr_t target);
        if (pred_o.valid !== valid) begin
            $display("CHECK FAILED pred_o.valid got %h expected %h", pred_o.valid, valid);
            errors++;
        end else if (valid && pred_o.lane !== lane) begin
            $display("CHECK FAILED pred_o.lane got %h expected %h", pred_o.lane, lane);
            errors++;
        end else if (valid && pred_o.target !== target) begin
            $display("CHECK FAILED pred_o.target got %h expected %h", pred_o.target, target);
            errors++;
        end
    endtask

    // ====================
    // Test sequence
    // ====================
    initial begin
        bp_pkg::addr_t held_pc;
        logic [31:0]   rnd;
        seed = 94508;
        errors = 0;
        checks = 0;
        model_pc = `BP_RESET_PC;
        shadow_valid = '0;
        for (int e = 0; e < `BP_ENTRIES; e++) begin
            shadow_target[e] = '0;
        end
        res_pending = '0;
        reset = 1'b0;
        fetch_i = '0;
        res_i = '0;
        stall_i = 1'b0;
        repeat (5) @(posedge clk);
        reset <= 1'b1;

        // After reset, no prediction and plain sequential fetch
        run_cycle('0, 1'b0, 1'b0);
        if (fetch_pc_o !== `BP_RESET_PC) begin
            $display("CHECK FAILED fetch_pc_o got %h expected %h", fetch_pc_o, `BP_RESET_PC);
            errors++;
        end
        expect_pred(1'b0, '0, '0);
        repeat (3) run_cycle('0, 1'b1, 1'b0);
        wait_for_pc(32'h0000_103C, 4);

        // Cold miss in lane 2, train it, then predict
        redirect_to(32'h0000_2000);
        run_cycle(5'b00100, 1'b1, 1'b0);
        expect_pred(1'b0, '0, '0);
        post_resolve(0, 1'b0, 1'b1, 32'h0000_2008, 32'h0000_3000);
        run_cycle('0, 1'b0, 1'b0);
        wait_for_pc(32'h0000_3000, 4);
        redirect_to(32'h0000_2000);
        run_cycle(5'b00100, 1'b1, 1'b0);
        expect_pred(1'b1, 3'd2, 32'h0000_3000);
        wait_for_pc(32'h0000_3000, 4);

        // Lanes 1 and 3 both trained, lane 1 wins
        post_resolve(0, 1'b0, 1'b1, 32'h0000_4004, 32'h0000_5000);
        post_resolve(1, 1'b0, 1'b1, 32'h0000_400C, 32'h0000_6000);
        run_cycle('0, 1'b0, 1'b0);
        redirect_to(32'h0000_4000);
        run_cycle(5'b01010, 1'b1, 1'b0);
        expect_pred(1'b1, 3'd1, 32'h0000_5000);
        wait_for_pc(32'h0000_5000, 4);
        redirect_to(32'h0000_4000);
        run_cycle(5'b01000, 1'b1, 1'b0);
        expect_pred(1'b1, 3'd3, 32'h0000_6000);

        // Branch mispredict and correct JALR leave the table alone
        post_resolve(0, 1'b1, 1'b1, 32'h0000_4004, 32'h0000_7000);
        post_resolve(1, 1'b0, 1'b0, 32'h0000_400C, 32'h0000_7100);
        run_cycle('0, 1'b0, 1'b0);
        redirect_to(32'h0000_4000);
        run_cycle(5'b01010, 1'b1, 1'b0);
        expect_pred(1'b1, 3'd1, 32'h0000_5000);
        // Lane 3 alone still sees its old target
        redirect_to(32'h0000_4000);
        run_cycle(5'b01000, 1'b1, 1'b0);
        expect_pred(1'b1, 3'd3, 32'h0000_6000);

        // Same index on ports 0 and 2, port 0 kept
        post_resolve(0, 1'b0, 1'b1, 32'h0000_4004, 32'h0000_8000);
        post_resolve(2, 1'b0, 1'b1, 32'h0000_4004, 32'h0000_9000);
        run_cycle('0, 1'b0, 1'b0);
        redirect_to(32'h0000_4000);
        run_cycle(5'b00010, 1'b1, 1'b0);
        expect_pred(1'b1, 3'd1, 32'h0000_8000);

        // Redirect beats prediction and stall, port 1 beats port 2
        redirect_to(32'h0000_4000);
        post_resolve(1, 1'b1, 1'b1, '0, 32'h0000_A000);
        post_resolve(2, 1'b0, 1'b1, 32'h0000_2008, 32'h0000_B000);
        run_cycle(5'b00010, 1'b1, 1'b1);
        wait_for_pc(32'h0000_A000, 4);

        // Stall alone holds the PC, even with a predicting JALR
        held_pc = fetch_pc_o;
        repeat (3) run_cycle(5'b00010, 1'b1, 1'b1);
        if (fetch_pc_o !== held_pc) begin
            $display("CHECK FAILED fetch_pc_o got %h expected %h", fetch_pc_o, held_pc);
            errors++;
        end

        // Aliasing, 0x4004 and 0x4044 share index 1
        post_resolve(0, 1'b0, 1'b1, 32'h0000_4004, 32'h0000_C000);
        run_cycle('0, 1'b0, 1'b0);
        post_resolve(0, 1'b0, 1'b1, 32'h0000_4044, 32'h0000_D000);
        run_cycle('0, 1'b0, 1'b0);
        wait_for_pc(32'h0000_D000, 4);
        redirect_to(32'h0000_4000);
        run_cycle(5'b00010, 1'b1, 1'b0);
        expect_pred(1'b1, 3'd1, 32'h0000_D000);
        redirect_to(32'h0000_4040);
        run_cycle(5'b00010, 1'b1, 1'b0);
        expect_pred(1'b1, 3'd1, 32'h0000_D000);

        // Random mix, checked by the compare process
        repeat (40) begin
            rnd = $random(seed);
            if (rnd[1:0] == 2'b00) begin
                post_resolve(int'(rnd[3:2]) % `BP_RES_PORTS, rnd[4], rnd[5],
                             fetch_pc_o + bp_pkg::addr_t'({rnd[8:6], 2'b00}),
                             32'h0000_4000 + bp_pkg::addr_t'({rnd[15:9], 2'b00}));
            end
            run_cycle(rnd[20:16], 1'b1, rnd[23:22] == 2'b00);
        end
        repeat (2) run_cycle('0, 1'b0, 1'b0);

        $display("Checks: %0d  Errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+source
source/bp_pkg.sv
source/jalr_predecode.sv
source/jalr_target_table.sv
source/fetch_pc_gen.sv
source/jalr_frontend.sv
sim/jalr_frontend_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the JALR front end testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module jalr_frontend_tb \
    -f vlog.f \
    --Mdir obj_dir -o sim_jalr_frontend

./obj_dir/sim_jalr_frontend | tee sim.log

if grep -q "^Everything OK$" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation reported errors, see sim.log"
    exit 1
fi
